// ==== sim.f ====
+incdir+src
+incdir+bench
src/nes_bus_pkg.sv
src/clock_divider.sv
src/dma_controller.sv
src/bus_arbiter.sv
src/io_decoder.sv
src/nes_bus_core.sv
bench/tb_nes_bus_core.sv

// ==== Bender.yml ====
package:
  name: nes_bus_core

sources:
  - include_dirs:
      - src
    files:
      - src/nes_bus_pkg.sv
      - src/clock_divider.sv
      - src/dma_controller.sv
      - src/bus_arbiter.sv
      - src/io_decoder.sv
      - src/nes_bus_core.sv
  - target: simulation
    include_dirs:
      - src
      - bench
    files:
      - bench/tb_nes_bus_core.sv

// ==== bench/tb_tasks.svh ====
/*
 * NES bus core test tasks
 * CPU cycle wait, typed compare tasks and the directed tests
 */

// Returns on the falling edge inside the next cpu_ce pulse
task automatic cpu_cycle();
	ce_clocks    = 0;
	write_pulses = 0;
	do begin
		@(negedge clk);
		ce_clocks++;
		if (mem_write)
			write_pulses++;
	end while (!cpu_ce && ce_clocks < CE_TIMEOUT);
	if (!cpu_ce) begin
		$display("Timeout: cpu_ce did not pulse within %0d clocks", CE_TIMEOUT);
		$display("TESTBENCH FAILED");
		$finish;
	end
endtask

// New CPU access, set up after the previous enable
task automatic drive_cpu(input nes_bus_pkg::addr_t addr, input nes_bus_pkg::data_t dout,
	input logic rnw);
	@(negedge clk);
	cpu_addr = addr;
	cpu_dout = dout;
	cpu_rnw  = rnw;
endtask

task automatic check_data(input string name, input nes_bus_pkg::data_t expected,
	input nes_bus_pkg::data_t actual);
	if (actual !== expected) begin
		$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		errors++;
	end
endtask

task automatic check_addr(input string name, input nes_bus_pkg::addr_t expected,
	input nes_bus_pkg::addr_t actual);
	if (actual !== expected) begin
		$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		errors++;
	end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("FAILED %s: expected %b, actual %b", name, expected, actual);
		errors++;
	end
endtask

task automatic check_count(input string name, input int expected, input int actual);
	if (actual != expected) begin
		$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
		errors++;
	end
endtask

task automatic finish_test(input string name, input int start_errors);
	if (errors == start_errors) begin
		$display("Test %s: ok", name);
		tests_passed++;
	end else begin
		$display("Test %s: %0d errors", name, errors - start_errors);
		tests_failed++;
	end
endtask

task automatic test_reset_divider();
	int start;
	start = errors;
	@(negedge clk);
	check_bit("reset_divider", 1'b0, pause_cpu);
	check_bit("reset_divider", 1'b0, dmc_ack);
	check_bit("reset_divider", 1'b0, mem_read);
	check_bit("reset_divider", 1'b0, mem_write);
	check_data("reset_divider", 8'h00, {5'b00000, joypad_out});
	check_data("reset_divider", 8'h00, {6'b000000, joypad_clock});
	cpu_cycle();  // Align to the first enable
	repeat (4) begin
		cpu_cycle();
		check_count("reset_divider", `NES_CPU_DIV, ce_clocks);  // Enable to enable spacing
	end
	finish_test("reset_divider", start);
endtask

task automatic test_memory_access();
	int start;
	start = errors;
	drive_cpu(16'h0123, 8'h00, 1'b1);
	cpu_cycle();
	check_bit("memory_access", 1'b1, mem_read);
	check_addr("memory_access", 16'h0123, mem_addr);
	check_data("memory_access", mem[16'h0123], cpu_din);
	drive_cpu(16'h0456, 8'h5a, 1'b0);
	cpu_cycle();
	check_count("memory_access", 1, write_pulses);  // One strobe per CPU write
	check_addr("memory_access", 16'h0456, mem_addr);
	check_data("memory_access", 8'h5a, mem_dout);
	finish_test("memory_access", start);
endtask

task automatic test_joypad_open_bus();
	int                 start;
	nes_bus_pkg::data_t bus_byte;  // Value the previous cycle left on the bus
	start = errors;
	drive_cpu(`NES_JOY1_REG, 8'had, 1'b0);
	cpu_cycle();
	bus_byte = 8'had;
	drive_cpu(`NES_JOY2_REG, 8'h00, 1'b1);
	joypad2_data = 5'h13;
	check_data("joypad_open_bus", 8'h05, {5'b00000, joypad_out});  // Low 3 bits of 0xad
	cpu_cycle();
	check_data("joypad_open_bus", 8'h02, {6'b000000, joypad_clock});  // Port 2 only
	check_data("joypad_open_bus", {bus_byte[7:5], 5'h13}, cpu_din);
	bus_byte = {bus_byte[7:5], 5'h13};
	drive_cpu(`NES_APU_BASE, 8'h00, 1'b1);
	cpu_cycle();
	check_bit("joypad_open_bus", 1'b0, mem_read);
	check_data("joypad_open_bus", bus_byte, cpu_din);  // Open bus unchanged
	finish_test("joypad_open_bus", start);
endtask

// Page copy to 2004h, with an optional DMC request after dmc_at writes
task automatic test_sprite_dma(input string name, input nes_bus_pkg::data_t page,
	input int dmc_at);
	int                 start;
	int                 count;
	int                 cycles;
	logic               acked;
	nes_bus_pkg::addr_t src;
	start  = errors;
	count  = 0;
	cycles = 0;
	acked  = 1'b0;
	drive_cpu(`NES_OAM_DMA_REG, page, 1'b0);
	cpu_cycle();  // Trigger write
	drive_cpu(16'h0000, 8'h00, 1'b1);  // Read held while paused
	do begin
		cpu_cycle();
		cycles++;
		if (mem_write) begin
			src = {page, count[7:0]};
			check_addr(name, `NES_OAM_DATA_REG, mem_addr);
			check_data(name, mem[src], mem_dout);
			count++;
		end
		if (dmc_ack) begin
			check_addr(name, DMC_ADDR, mem_addr);
			check_data(name, mem[DMC_ADDR], cpu_din);
			acked = 1'b1;
			@(negedge clk);
			dmc_trigger = 1'b0;
		end else if (count == dmc_at && !dmc_trigger && !acked) begin
			@(negedge clk);
			dmc_trigger = 1'b1;
			dmc_addr    = DMC_ADDR;
		end
	end while (pause_cpu && cycles < 700);
	if (pause_cpu) begin
		$display("%s: pause_cpu still high after %0d CPU cycles", name, cycles);
		errors++;
	end
	check_count(name, 256, count);
	if (dmc_at >= 0 && !acked) begin
		$display("%s: DMC request raised mid-transfer was never acknowledged", name);
		errors++;
	end
	finish_test(name, start);
endtask

task automatic test_dmc_fetch();
	int start;
	int cycles;
	start  = errors;
	cycles = 0;
	drive_cpu(16'h0000, 8'h00, 1'b1);
	dmc_trigger = 1'b1;
	dmc_addr    = DMC_ADDR;
	do begin
		cpu_cycle();
		cycles++;
	end while (!dmc_ack && cycles < 8);
	if (dmc_ack) begin
		check_addr("dmc_fetch", DMC_ADDR, mem_addr);
		check_data("dmc_fetch", mem[DMC_ADDR], cpu_din);
	end else begin
		$display("dmc_fetch: dmc_ack did not arrive within 8 CPU cycles");
		errors++;
	end
	@(negedge clk);
	dmc_trigger = 1'b0;
	cpu_cycle();
	check_bit("dmc_fetch", 1'b0, pause_cpu);  // CPU released once the request drops
	cpu_cycle();
	check_bit("dmc_fetch", 1'b0, dmc_ack);  // No second fetch on the next even cycle
	finish_test("dmc_fetch", start);
endtask

// ==== bench/tb_nes_bus_core.sv ====
/*
 * Testbench for the NES bus core
 * Acts as CPU port and DMC requester, models a 64 KB memory, runs directed tests
 */

`timescale 1ns/1ps
`include "nes_bus_consts.svh"

module tb_nes_bus_core;

	localparam int                 CE_TIMEOUT = 64;        // Master clocks per CPU cycle, max
	localparam nes_bus_pkg::addr_t DMC_ADDR   = 16'hc5a7;  // Sample byte in cartridge space

	logic                     clk;
	logic                     reset;
	nes_bus_pkg::addr_t       cpu_addr;
	nes_bus_pkg::data_t       cpu_dout;
	logic                     cpu_rnw;
	logic                     dmc_trigger;
	nes_bus_pkg::addr_t       dmc_addr;
	nes_bus_pkg::data_t       mem_din;
	logic [`NES_JOY_BITS-1:0] joypad1_data;
	logic [`NES_JOY_BITS-1:0] joypad2_data;
	logic                     cpu_ce;
	nes_bus_pkg::data_t       cpu_din;
	logic                     pause_cpu;
	logic                     dmc_ack;
	nes_bus_pkg::addr_t       mem_addr;
	nes_bus_pkg::data_t       mem_dout;
	logic                     mem_read;
	logic                     mem_write;
	logic [2:0]               joypad_out;
	logic [1:0]               joypad_clock;

	nes_bus_pkg::data_t mem [0:65535];  // Memory model
	int                 seed;
	int                 errors;
	int                 tests_passed;
	int                 tests_failed;
	int                 ce_clocks;     // Clocks seen by the last CPU cycle wait
	int                 write_pulses;  // mem_write clocks in that wait

	nes_bus_core uut (
		.clk          (clk),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.cpu_rnw      (cpu_rnw),
		.dmc_trigger  (dmc_trigger),
		.dmc_addr     (dmc_addr),
		.mem_din      (mem_din),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.cpu_ce       (cpu_ce),
		.cpu_din      (cpu_din),
		.pause_cpu    (pause_cpu),
		.dmc_ack      (dmc_ack),
		.mem_addr     (mem_addr),
		.mem_dout     (mem_dout),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

	assign mem_din = mem[mem_addr];  // Combinational read

	always @(posedge clk) begin
		if (mem_write)
			mem[mem_addr] <= mem_dout;
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	`include "tb_tasks.svh"

	initial begin
		seed         = 58064;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < 65536; i++)
			mem[i] = $random(seed);
		reset        = 1'b1;
		cpu_addr     = 16'h0000;
		cpu_dout     = 8'h00;
		cpu_rnw      = 1'b1;  // Idle CPU reads
		dmc_trigger  = 1'b0;
		dmc_addr     = 16'h0000;
		joypad1_data = '0;
		joypad2_data = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		test_reset_divider();
		test_memory_access();
		test_joypad_open_bus();
		test_sprite_dma("sprite_dma", 8'h80, -1);
		test_dmc_fetch();
		test_sprite_dma("sprite_dma_dmc", 8'h03, 100);  // DMC raised after write 100

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== src/nes_bus_core.sv ====
/*
 * NES bus-mastering core
 * Clock divider, DMA controller, bus arbiter and I/O decoder around an
 * external CPU port and an external memory
 */

`timescale 1ns/1ps
`include "nes_bus_consts.svh"

module nes_bus_core (
	input  logic                     clk,
	input  logic                     reset,
	input  nes_bus_pkg::addr_t       cpu_addr,
	input  nes_bus_pkg::data_t       cpu_dout,
	input  logic                     cpu_rnw,
	input  logic                     dmc_trigger,
	input  nes_bus_pkg::addr_t       dmc_addr,
	input  nes_bus_pkg::data_t       mem_din,
	input  logic [`NES_JOY_BITS-1:0] joypad1_data,
	input  logic [`NES_JOY_BITS-1:0] joypad2_data,
	output logic                     cpu_ce,
	output nes_bus_pkg::data_t       cpu_din,
	output logic                     pause_cpu,
	output logic                     dmc_ack,
	output nes_bus_pkg::addr_t       mem_addr,
	output nes_bus_pkg::data_t       mem_dout,
	output logic                     mem_read,
	output logic                     mem_write,
	output logic [2:0]               joypad_out,
	output logic [1:0]               joypad_clock
);

	logic                 odd_cycle;
	nes_bus_pkg::addr_t   dma_addr;
	nes_bus_pkg::data_t   dma_data;
	logic                 dma_read;
	logic                 dma_active;
	nes_bus_pkg::addr_t   bus_addr;   // Address of the granted master
	nes_bus_pkg::data_t   bus_data;
	logic                 bus_read;
	logic                 bus_write;
	nes_bus_pkg::region_e region;

	clock_divider u_clock_divider (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dma_controller u_dma_controller (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.odd_cycle   (odd_cycle),
		.bus_addr    (bus_addr),
		.bus_write   (bus_write),
		.cpu_rnw     (cpu_rnw),
		.cpu_dout    (cpu_dout),
		.read_data   (cpu_din),    // DMA reads come back through the read mux
		.dmc_trigger (dmc_trigger),
		.dmc_addr    (dmc_addr),
		.dma_addr    (dma_addr),
		.dma_data    (dma_data),
		.dma_read    (dma_read),
		.dma_active  (dma_active),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu)
	);

	bus_arbiter u_bus_arbiter (
		.cpu_ce     (cpu_ce),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.cpu_rnw    (cpu_rnw),
		.dma_addr   (dma_addr),
		.dma_data   (dma_data),
		.dma_read   (dma_read),
		.dma_active (dma_active),
		.region     (region),
		.bus_addr   (bus_addr),
		.bus_data   (bus_data),
		.bus_read   (bus_read),
		.bus_write  (bus_write),
		.mem_addr   (mem_addr),
		.mem_dout   (mem_dout),
		.mem_read   (mem_read),
		.mem_write  (mem_write)
	);

	io_decoder u_io_decoder (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.bus_addr     (bus_addr),
		.bus_data     (bus_data),
		.bus_read     (bus_read),
		.bus_write    (bus_write),
		.mem_din      (mem_din),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.region       (region),
		.cpu_din      (cpu_din),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

endmodule

// ==== src/io_decoder.sv ====
/*
 * I/O decoder
 * Classifies bus addresses, handles the joypad strobe and clocks, keeps the
 * open-bus byte and muxes the data returned to the CPU
 */

`timescale 1ns/1ps
`include "nes_bus_consts.svh"

module io_decoder (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     cpu_ce,
	input  nes_bus_pkg::addr_t       bus_addr,
	input  nes_bus_pkg::data_t       bus_data,
	input  logic                     bus_read,
	input  logic                     bus_write,
	input  nes_bus_pkg::data_t       mem_din,
	input  logic [`NES_JOY_BITS-1:0] joypad1_data,
	input  logic [`NES_JOY_BITS-1:0] joypad2_data,
	output nes_bus_pkg::region_e     region,
	output nes_bus_pkg::data_t       cpu_din,
	output logic [2:0]               joypad_out,    // Strobe and expansion bits
	output logic [1:0]               joypad_clock   // One bit per port
);

	nes_bus_pkg::data_t       open_bus;  // Last byte seen on the data bus
	logic [`NES_JOY_BITS-1:0] joy_data;
	logic                     joy_rd;

	// Joypads take priority inside the APU range
	always_comb begin
		if (bus_addr == `NES_JOY1_REG || bus_addr == `NES_JOY2_REG)
			region = nes_bus_pkg::region_joy;
		else if (bus_addr >= `NES_PPU_BASE && bus_addr <= `NES_PPU_END)
			region = nes_bus_pkg::region_ppu;
		else if (bus_addr >= `NES_APU_BASE && bus_addr <= `NES_APU_END)
			region = nes_bus_pkg::region_apu;
		else
			region = nes_bus_pkg::region_mem;
	end

	assign joy_data = (bus_addr == `NES_JOY2_REG) ? joypad2_data : joypad1_data;
	assign joy_rd   = cpu_ce && bus_read && (region == nes_bus_pkg::region_joy);

	// Shift pulse for the port being read
	assign joypad_clock = {joy_rd && (bus_addr == `NES_JOY2_REG),
		joy_rd && (bus_addr == `NES_JOY1_REG)};

	always_comb begin
		if (bus_write) begin
			cpu_din = bus_data;  // Writer drives the bus
		end else begin
			case (region)
				nes_bus_pkg::region_joy: cpu_din = {open_bus[7:`NES_JOY_BITS], joy_data};
				nes_bus_pkg::region_mem: cpu_din = mem_din;
				default:                 cpu_din = open_bus;  // PPU/APU not modelled
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_ce)
			open_bus <= cpu_din;
	end

	// Strobe latch, low 3 bits of a 4016h write
	always_ff @(posedge clk) begin
		if (reset)
			joypad_out <= 3'b000;
		else if (cpu_ce && bus_write && bus_addr == `NES_JOY1_REG)
			joypad_out <= bus_data[2:0];
	end

endmodule

// ==== src/bus_arbiter.sv ====
/*
 * Bus arbiter
 * Grants the shared bus to the CPU or the DMA controller and forms the
 * memory strobes for the granted access
 */

`timescale 1ns/1ps
`include "nes_bus_consts.svh"

module bus_arbiter (
	input  logic                  cpu_ce,
	input  nes_bus_pkg::addr_t    cpu_addr,
	input  nes_bus_pkg::data_t    cpu_dout,
	input  logic                  cpu_rnw,
	input  nes_bus_pkg::addr_t    dma_addr,
	input  nes_bus_pkg::data_t    dma_data,
	input  logic                  dma_read,
	input  logic                  dma_active,
	input  nes_bus_pkg::region_e  region,
	output nes_bus_pkg::addr_t    bus_addr,
	output nes_bus_pkg::data_t    bus_data,
	output logic                  bus_read,
	output logic                  bus_write,
	output nes_bus_pkg::addr_t    mem_addr,
	output nes_bus_pkg::data_t    mem_dout,
	output logic                  mem_read,
	output logic                  mem_write
);

	nes_bus_pkg::bus_master_e grant;

	// DMA wins whenever it asks, the CPU is paused by then
	assign grant = dma_active ? nes_bus_pkg::master_dma : nes_bus_pkg::master_cpu;

	always_comb begin
		if (grant == nes_bus_pkg::master_dma) begin
			bus_addr = dma_addr;
			bus_data = dma_data;
			bus_read = dma_read;
		end else begin
			bus_addr = cpu_addr;
			bus_data = cpu_dout;
			bus_read = cpu_rnw;
		end
	end

	assign bus_write = !bus_read;

	// External memory sees one strobe per CPU cycle
	assign mem_addr  = bus_addr;
	assign mem_dout  = bus_data;
	assign mem_read  = cpu_ce && bus_read && (region == nes_bus_pkg::region_mem);
	assign mem_write = cpu_ce && bus_write;  // Writes reach every region

	// DMA writes only ever target the OAM data port
	a_dma_write_oam: assert property (@(negedge cpu_ce)
		(mem_write && grant == nes_bus_pkg::master_dma) |->
		(mem_addr == `NES_OAM_DATA_REG));

endmodule

// ==== src/dma_controller.sv ====
/*
 * Sprite and DMC DMA controller
 * Copies a 256-byte page to OAM on a 4014h write, serves DMC sample fetches
 * and holds the CPU while either is pending
 */

`timescale 1ns/1ps
`include "nes_bus_consts.svh"

module dma_controller (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               odd_cycle,
	input  nes_bus_pkg::addr_t bus_addr,
	input  logic               bus_write,
	input  logic               cpu_rnw,
	input  nes_bus_pkg::data_t cpu_dout,    // Page number on a 4014h write
	input  nes_bus_pkg::data_t read_data,   // Byte returned on the bus
	input  logic               dmc_trigger,
	input  nes_bus_pkg::addr_t dmc_addr,
	output nes_bus_pkg::addr_t dma_addr,
	output nes_bus_pkg::data_t dma_data,
	output logic               dma_read,
	output logic               dma_active,  // DMA owns the bus this cycle
	output logic               dmc_ack,
	output logic               pause_cpu
);

	nes_bus_pkg::spr_state_e spr_state;
	nes_bus_pkg::dmc_state_e dmc_state;
	nes_bus_pkg::addr_t      spr_addr;  // Source pointer, page in the high byte
	nes_bus_pkg::data_t      spr_data;  // Held from the even read to the odd write
	logic                    oam_trigger;
	logic [8:0]              spr_next;  // Low byte plus carry out

	assign oam_trigger = bus_write && (bus_addr == `NES_OAM_DMA_REG);
	assign spr_next    = {1'b0, spr_addr[7:0]} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= nes_bus_pkg::spr_idle;
			dmc_state <= nes_bus_pkg::dmc_idle;
		end else if (cpu_ce) begin
			// DMC only halts the CPU during a read, and lands on an even cycle
			case (dmc_state)
				nes_bus_pkg::dmc_idle:
					if (dmc_trigger && cpu_rnw && !odd_cycle)
						dmc_state <= nes_bus_pkg::dmc_pending;
				default:
					if (!odd_cycle)
						dmc_state <= nes_bus_pkg::dmc_idle;  // Ack cycle done
			endcase

			case (spr_state)
				nes_bus_pkg::spr_idle:
					if (oam_trigger)
						spr_state <= nes_bus_pkg::spr_wait;
				nes_bus_pkg::spr_wait:
					if (cpu_rnw && odd_cycle)
						spr_state <= nes_bus_pkg::spr_run;  // First read on next even
				nes_bus_pkg::spr_run: begin
					if (!odd_cycle && dmc_ack)
						spr_state <= nes_bus_pkg::spr_wait;  // DMC stole the read slot
					else if (odd_cycle && spr_next[8])
						spr_state <= nes_bus_pkg::spr_idle;  // Last write of the page
				end
				default:
					spr_state <= nes_bus_pkg::spr_idle;
			endcase
		end
	end

	// Pointer and data latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (spr_state == nes_bus_pkg::spr_idle && oam_trigger)
				spr_addr <= {cpu_dout, 8'h00};
			else if (spr_state == nes_bus_pkg::spr_run && odd_cycle)
				spr_addr[7:0] <= spr_next[7:0];  // Advance after each write
			if (spr_state == nes_bus_pkg::spr_run && !odd_cycle && !dmc_ack)
				spr_data <= read_data;
		end
	end

	assign dmc_ack    = (dmc_state == nes_bus_pkg::dmc_pending) && !odd_cycle;
	assign dma_active = dmc_ack || (spr_state == nes_bus_pkg::spr_run);
	assign dma_read   = !odd_cycle;  // Reads even, writes odd
	assign dma_data   = spr_data;
	assign pause_cpu  = (spr_state != nes_bus_pkg::spr_idle) || dmc_trigger;

	always_comb begin
		if (dmc_ack)
			dma_addr = dmc_addr;
		else if (!odd_cycle)
			dma_addr = spr_addr;
		else
			dma_addr = `NES_OAM_DATA_REG;
	end

	// Acknowledge only while the requester still holds its request
	a_dmc_held: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> dmc_trigger);

	// Low byte never wraps to zero while the transfer runs
	a_spr_nowrap: assert property (@(posedge clk) disable iff (reset)
		(spr_state == nes_bus_pkg::spr_run && $changed(spr_addr[7:0])) |->
		(spr_addr[7:0] != 8'h00));

endmodule

// ==== src/clock_divider.sv ====
/*
 * CPU clock generator
 * Divides the master clock into a one-clock CPU enable and tracks cycle parity
 */

`timescale 1ns/1ps
`include "nes_bus_consts.svh"

module clock_divider (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,     // One master clock wide
	output logic odd_cycle   // 1 = odd CPU cycle, 0 = even
);

	localparam int CNT_W = $clog2(`NES_CPU_DIV);

	logic [CNT_W-1:0] div_cnt;

	// Enable on the last count of each CPU cycle
	assign cpu_ce = (div_cnt == CNT_W'(`NES_CPU_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (cpu_ce) begin
			div_cnt <= '0;  // Wrap
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Parity starts odd so the first DMA read lands one cycle later
	always_ff @(posedge clk) begin
		if (reset)
			odd_cycle <= 1'b1;
		else if (cpu_ce)
			odd_cycle <= ~odd_cycle;
	end

	// Next enable follows exactly one CPU cycle later
	a_ce_period: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |-> ##(`NES_CPU_DIV) cpu_ce);

endmodule

// ==== src/nes_bus_pkg.sv ====
/*
 * NES bus core types
 * Bus address and data types plus the DMA, grant and region encodings
 */

package nes_bus_pkg;

	typedef logic [15:0] addr_t;  // CPU address space
	typedef logic [7:0]  data_t;

	// Sprite DMA sequencer, bit 0 set whenever the CPU is held
	typedef enum logic [1:0] {
		spr_idle = 2'b00,
		spr_wait = 2'b01,  // Triggered, waiting for a CPU read on an odd cycle
		spr_run  = 2'b11   // Read/write pairs in progress
	} spr_state_e;

	typedef enum logic {
		dmc_idle    = 1'b0,
		dmc_pending = 1'b1  // Sample fetch waits for the next even cycle
	} dmc_state_e;

	typedef enum logic {
		master_cpu = 1'b0,
		master_dma = 1'b1
	} bus_master_e;

	typedef enum logic [1:0] {
		region_mem = 2'b00,  // RAM and cartridge space
		region_ppu = 2'b01,
		region_apu = 2'b10,
		region_joy = 2'b11
	} region_e;

endpackage

// ==== src/nes_bus_consts.svh ====
/*
 * NES bus core constants
 * Master clock divide ratio, register addresses and address region bounds
 */

`ifndef NES_BUS_CONSTS_SVH
`define NES_BUS_CONSTS_SVH

// Master clocks per CPU cycle
`define NES_CPU_DIV 12

// Sprite DMA page register and its destination
`define NES_OAM_DMA_REG  16'h4014
`define NES_OAM_DATA_REG 16'h2004

// Joypad ports, mapped inside the APU range
`define NES_JOY1_REG 16'h4016
`define NES_JOY2_REG 16'h4017

// PPU registers and their mirrors
`define NES_PPU_BASE 16'h2000
`define NES_PPU_END  16'h3FFF

// APU and I/O registers
`define NES_APU_BASE 16'h4000
`define NES_APU_END  16'h4017

// Serial data bits returned by each joypad read
`define NES_JOY_BITS 5

`endif
